// File: run_sim.sh
#!/bin/sh
verilator --binary --timing --assert -f src.f --top-module aes_dec_tb -o aes_dec_sim \
  && ./obj_dir/aes_dec_sim | tee /dev/stderr | grep -q "All checks passed" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// File: src.f
+incdir+verilog
verilog/aes_dec_pkg.sv
verilog/aes_dec_ctrl.sv
verilog/aes_key_expand.sv
verilog/aes_inv_round.sv
verilog/aes_dec_top.sv
tb/aes_dec_tb.sv

// File: tb/aes_dec_tb.sv
// AES-128 decryption core testbench
// FIPS-197 vectors, handshake timing checks and result report

`timescale 1ns/10ps
`default_nettype none

module aes_dec_tb import aes_dec_pkg::*; ();

  // FIPS-197 Appendix C.1
  localparam block_t c1_key = 128'h000102030405060708090a0b0c0d0e0f;
  localparam block_t c1_ct  = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
  localparam block_t c1_pt  = 128'h00112233445566778899aabbccddeeff;
  // FIPS-197 Appendix B
  localparam block_t b_key  = 128'h2b7e151628aed2a6abf7158809cf4f3c;
  localparam block_t b_ct   = 128'h3925841d02dc09fbdc118597196a0b32;
  localparam block_t b_pt   = 128'h3243f6a8885a308d313198a2e0370734;

  logic   clk;
  logic   arst_n;
  block_t key;
  logic   key_valid;
  block_t ct;
  logic   start;
  logic   key_ready;
  logic   busy;
  block_t pt;
  logic   done;

  int     errors;
  int     test_errors;
  int     tests;
  int     cycles;
  int     n_done;
  block_t result;
  string  test_name;

  aes_dec_top i_aes_dec_top (
    .clk       (clk),
    .arst_n    (arst_n),
    .key       (key),
    .key_valid (key_valid),
    .ct        (ct),
    .start     (start),
    .key_ready (key_ready),
    .busy      (busy),
    .pt        (pt),
    .done      (done)
  );

  always #2 clk = ~clk;

  // Handshake rules on every cycle
  assert property (@(posedge clk) disable iff (!arst_n) done |-> !busy)
    else begin
      errors++;
      $display("done and busy were high in the same cycle");
    end
  assert property (@(posedge clk) disable iff (!arst_n) busy |-> key_ready)
    else begin
      errors++;
      $display("key_ready dropped during a decryption");
    end

  task automatic begin_test(input string name);
    test_name   = name;
    test_errors = errors;
  endtask

  task automatic end_test();
    tests++;
    if (errors == test_errors) begin
      $display("test %s: ok", test_name);
    end else begin
      $display("test %s: %0d failed checks", test_name, errors - test_errors);
    end
  endtask

  task automatic fail_note(input string what);
    errors++;
    $display("test %s: %s", test_name, what);
  endtask

  task automatic check_value(input string what, input block_t exp, input block_t act);
    assert (act == exp) else begin
      errors++;
      $display("** Error: %s: %s expected %h, got %h", test_name, what, exp, act);
    end
  endtask

  task automatic check_count(input string what, input int exp, input int act);
    assert (act == exp) else begin
      errors++;
      $display("** Error: %s: %s expected %0d, got %0d", test_name, what, exp, act);
    end
  endtask

  // Called on a falling edge, returns once key_ready is high
  task automatic load_key(input block_t k);
    int cnt;
    key       = k;
    key_valid = 1'b1;
    @(negedge clk);
    key_valid = 1'b0;
    assert (!key_ready) else fail_note("key_ready did not drop after key_valid");
    cnt = 0;
    while (!key_ready && cnt < 40) begin
      @(negedge clk);
      cnt++;
    end
    assert (key_ready) else fail_note("timed out waiting for key_ready");
    check_count("key_ready latency", 11, cnt);
  endtask

  // Called on a falling edge, returns on the falling edge where done is high
  task automatic decrypt(input block_t c, output int lat, output block_t res);
    ct    = c;
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    assert (busy) else fail_note("busy did not rise after start");
    lat = 0;
    while (!done && lat < 40) begin
      @(negedge clk);
      lat++;
    end
    assert (done) else fail_note("timed out waiting for done");
    res = pt;
  endtask

  // Whole run bounded
  initial begin
    #20000;
    $display("simulation stopped by the watchdog");
    $display("Checks failed");
    $finish;
  end

  initial begin
    clk       = 1'b0;
    arst_n    = 1'b0;
    key       = '0;
    key_valid = 1'b0;
    ct        = '0;
    start     = 1'b0;
    errors    = 0;
    tests     = 0;
    repeat (10) @(negedge clk);
    arst_n = 1'b1;

    begin_test("reset_state");
    check_count("key_ready", 0, key_ready);
    check_count("busy", 0, busy);
    check_count("done", 0, done);
    check_value("pt", '0, pt);
    end_test();

    // No key yet, so this start must be dropped
    begin_test("start_without_key");
    ct    = c1_ct;
    start = 1'b1;
    @(negedge clk);
    start  = 1'b0;
    n_done = 0;
    repeat (30) begin
      if (done || busy) n_done++;
      @(negedge clk);
    end
    check_count("done or busy cycles", 0, n_done);
    end_test();

    begin_test("key_load_c1");
    load_key(c1_key);
    end_test();

    begin_test("decrypt_c1");
    decrypt(c1_ct, cycles, result);
    check_count("done latency", 11, cycles);
    check_value("pt", c1_pt, result);
    @(negedge clk);
    assert (!done) else fail_note("done lasted more than one cycle");
    end_test();

    // Second start with another block and a new key land while busy
    begin_test("start_while_busy");
    ct    = c1_ct;
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    repeat (3) @(negedge clk);
    assert (busy) else fail_note("busy low in the middle of a decryption");
    ct        = b_ct;
    key       = b_key;
    start     = 1'b1;
    key_valid = 1'b1;
    @(negedge clk);
    start     = 1'b0;
    key_valid = 1'b0;
    n_done    = 0;
    repeat (30) begin
      if (done) n_done++;
      @(negedge clk);
    end
    check_count("done pulses", 1, n_done);
    check_value("held pt", c1_pt, pt);
    check_count("key_ready", 1, key_ready);
    end_test();

    // Each start goes out on the done cycle of the one before
    begin_test("back_to_back");
    repeat (3) begin
      decrypt(c1_ct, cycles, result);
      check_count("done latency", 11, cycles);
      check_value("pt", c1_pt, result);
    end
    @(negedge clk);
    end_test();

    begin_test("rekey_fips_b");
    load_key(b_key);
    decrypt(b_ct, cycles, result);
    check_count("done latency", 11, cycles);
    check_value("pt", b_pt, result);
    @(negedge clk);
    end_test();

    $display("%0d tests run, %0d failed checks", tests, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/aes_dec_ctrl.sv
// AES-128 decryption controller
// FSM for key expansion and the inverse round sequence

`timescale 1ns/10ps
`default_nettype none

module aes_dec_ctrl import aes_dec_pkg::*; (
  input  wire logic  clk,
  input  wire logic  arst_n,
  input  wire logic  key_valid,
  input  wire logic  start,
  output key_ctrl_t  key_cmd,
  output round_ctrl_t round_cmd,
  output logic       key_ready,
  output logic       busy,
  output logic       done
);

  typedef enum logic [1:0] {
    st_idle,
    st_expand,
    st_decrypt
  } ctrl_state_e;

  ctrl_state_e state;

  // key_cmd.key_idx doubles as the round counter
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state     <= st_idle;
      key_cmd   <= '0;
      round_cmd <= '0;
      key_ready <= 1'b0;
      busy      <= 1'b0;
      done      <= 1'b0;
    end else begin
      // Strobes last one cycle
      done              <= 1'b0;
      key_cmd.key_load  <= 1'b0;
      key_cmd.key_step  <= 1'b0;
      round_cmd         <= '0;

      case (state)
        st_idle: begin
          // New key wins over a start in the same cycle
          if (key_valid) begin
            key_cmd.key_load <= 1'b1;
            key_cmd.key_idx  <= '0;
            key_ready        <= 1'b0;
            state            <= st_expand;
          end else if (start && key_ready) begin
            // Load uses the last round key
            round_cmd.load  <= 1'b1;
            key_cmd.key_idx <= num_rounds;
            busy            <= 1'b1;
            state           <= st_decrypt;
          end
        end

        st_expand: begin
          if (key_cmd.key_idx == num_rounds) begin
            // Round key 10 written on this edge
            key_ready <= 1'b1;
            state     <= st_idle;
          end else begin
            key_cmd.key_step <= 1'b1;
            key_cmd.key_idx  <= key_cmd.key_idx + 4'd1;
          end
        end

        st_decrypt: begin
          if (round_cmd.last) begin
            // Final round lands with done
            busy  <= 1'b0;
            done  <= 1'b1;
            state <= st_idle;
          end else begin
            // Keys 9 down to 0
            round_cmd.step  <= 1'b1;
            round_cmd.last  <= (key_cmd.key_idx == 4'd1);
            key_cmd.key_idx <= key_cmd.key_idx - 4'd1;
          end
        end

        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: verilog/aes_dec_pkg.sv
// AES-128 decryption core shared definitions
// State and block types, control structs, S-box lookups and byte transposes

`default_nettype none

package aes_dec_pkg;

  // Forward and inverse S-box constants
  `include "aes_sbox_tables.svh"

  // Row-major state, byte index is 4*row + col
  typedef logic [15:0][7:0] state_t;

  // FIPS byte order, byte 0 in the top bits
  typedef logic [127:0] block_t;

  // Round key index 0..10
  typedef logic [3:0] round_idx_t;

  // Last round key index for AES-128
  localparam round_idx_t num_rounds = 4'd10;

  // Controller to key schedule
  typedef struct packed {
    logic       key_load;
    logic       key_step;
    round_idx_t key_idx;
  } key_ctrl_t;

  // Controller to round datapath
  typedef struct packed {
    logic load;
    logic step;
    logic last;
  } round_ctrl_t;

  function automatic logic [7:0] sbox_fwd(input logic [7:0] b);
    return sbox_fwd_table[b];
  endfunction

  function automatic logic [7:0] sbox_inv(input logic [7:0] b);
    return sbox_inv_table[b];
  endfunction

  // FIPS byte 4*col + row lands in state[4*row + col]
  function automatic state_t to_state(input block_t b);
    state_t s;
    int r;
    int c;
    for (r = 0; r < 4; r++) begin
      for (c = 0; c < 4; c++) begin
        s[4*r + c] = b[127 - 8*(4*c + r) -: 8];
      end
    end
    return s;
  endfunction

  // Back to column-major FIPS order
  function automatic block_t to_block(input state_t s);
    block_t b;
    int r;
    int c;
    for (r = 0; r < 4; r++) begin
      for (c = 0; c < 4; c++) begin
        b[127 - 8*(4*c + r) -: 8] = s[4*r + c];
      end
    end
    return b;
  endfunction

endpackage

`default_nettype wire

// File: verilog/aes_dec_top.sv
// AES-128 decryption core top level
// Controller, key schedule and inverse round datapath

`timescale 1ns/10ps
`default_nettype none

module aes_dec_top import aes_dec_pkg::*; (
  input  wire logic   clk,
  input  wire logic   arst_n,
  input  wire block_t key,
  input  wire logic   key_valid,
  input  wire block_t ct,
  input  wire logic   start,
  output logic        key_ready,
  output logic        busy,
  output block_t      pt,
  output logic        done
);

  // Command buses from the controller
  key_ctrl_t   key_cmd;
  round_ctrl_t round_cmd;

  // Selected round key
  state_t round_key;

  aes_dec_ctrl i_aes_dec_ctrl (
    .clk       (clk),
    .arst_n    (arst_n),
    .key_valid (key_valid),
    .start     (start),
    .key_cmd   (key_cmd),
    .round_cmd (round_cmd),
    .key_ready (key_ready),
    .busy      (busy),
    .done      (done)
  );

  aes_key_expand i_aes_key_expand (
    .clk       (clk),
    .arst_n    (arst_n),
    .key       (key),
    .key_cmd   (key_cmd),
    .round_key (round_key)
  );

  aes_inv_round i_aes_inv_round (
    .clk       (clk),
    .arst_n    (arst_n),
    .ct        (ct),
    .round_cmd (round_cmd),
    .round_key (round_key),
    .pt        (pt)
  );

endmodule

`default_nettype wire

// File: verilog/aes_inv_round.sv
// AES-128 inverse round datapath
// State register, InvShiftRows, InvSubBytes, AddRoundKey, InvMixColumns

`timescale 1ns/10ps
`default_nettype none

module aes_inv_round import aes_dec_pkg::*; (
  input  wire logic        clk,
  input  wire logic        arst_n,
  input  wire block_t      ct,
  input  wire round_ctrl_t round_cmd,
  input  wire state_t      round_key,
  output block_t           pt
);

  state_t st;
  state_t st_next;
  state_t shifted;
  state_t subbed;
  state_t keyed;
  state_t mixed;

  // GF(2^8) multiply by a 4-bit coefficient
  function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [3:0] coef);
    logic [7:0] x2;
    logic [7:0] x4;
    logic [7:0] x8;
    x2 = {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
    x4 = {x2[6:0], 1'b0} ^ (x2[7] ? 8'h1b : 8'h00);
    x8 = {x4[6:0], 1'b0} ^ (x4[7] ? 8'h1b : 8'h00);
    return (coef[0] ? a : 8'h00) ^ (coef[1] ? x2 : 8'h00) ^
           (coef[2] ? x4 : 8'h00) ^ (coef[3] ? x8 : 8'h00);
  endfunction

  // Row r rotated right by r
  always_comb begin
    int r;
    int c;
    for (r = 0; r < 4; r++) begin
      for (c = 0; c < 4; c++) begin
        shifted[4*r + c] = st[4*r + ((c + 4 - r) % 4)];
      end
    end
  end

  // InvSubBytes and AddRoundKey
  always_comb begin
    int i;
    for (i = 0; i < 16; i++) begin
      subbed[i] = sbox_inv(shifted[i]);
    end
    keyed = subbed ^ round_key;
  end

  // InvMixColumns over each column
  always_comb begin
    int c;
    logic [7:0] a0;
    logic [7:0] a1;
    logic [7:0] a2;
    logic [7:0] a3;
    for (c = 0; c < 4; c++) begin
      a0 = keyed[c];
      a1 = keyed[4 + c];
      a2 = keyed[8 + c];
      a3 = keyed[12 + c];
      mixed[c]      = gf_mul(a0, 4'he) ^ gf_mul(a1, 4'hb) ^
                      gf_mul(a2, 4'hd) ^ gf_mul(a3, 4'h9);
      mixed[4 + c]  = gf_mul(a0, 4'h9) ^ gf_mul(a1, 4'he) ^
                      gf_mul(a2, 4'hb) ^ gf_mul(a3, 4'hd);
      mixed[8 + c]  = gf_mul(a0, 4'hd) ^ gf_mul(a1, 4'h9) ^
                      gf_mul(a2, 4'he) ^ gf_mul(a3, 4'hb);
      mixed[12 + c] = gf_mul(a0, 4'hb) ^ gf_mul(a1, 4'hd) ^
                      gf_mul(a2, 4'h9) ^ gf_mul(a3, 4'he);
    end
  end

  // Final round skips InvMixColumns
  assign st_next = round_cmd.last ? keyed : mixed;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      st <= '0;
    end else if (round_cmd.load) begin
      // Initial AddRoundKey with key 10
      st <= to_state(ct) ^ round_key;
    end else if (round_cmd.step) begin
      st <= st_next;
    end
  end

  // Back to FIPS byte order
  assign pt = to_block(st);

endmodule

`default_nettype wire

// File: verilog/aes_key_expand.sv
// AES-128 forward key expansion
// Round constant function and eleven-entry round key store

`timescale 1ns/10ps
`default_nettype none

module aes_key_expand import aes_dec_pkg::*; (
  input  wire logic      clk,
  input  wire logic      arst_n,
  input  wire block_t    key,
  input  wire key_ctrl_t key_cmd,
  output state_t         round_key
);

  // Round keys kept in row-major order
  state_t rk_mem [11];

  // Previous round key in FIPS word order
  block_t prev_key;
  block_t next_key;

  // Round constant for round key i
  function automatic logic [7:0] rcon(input round_idx_t idx);
    case (idx)
      4'd1:    return 8'h01;
      4'd2:    return 8'h02;
      4'd3:    return 8'h04;
      4'd4:    return 8'h08;
      4'd5:    return 8'h10;
      4'd6:    return 8'h20;
      4'd7:    return 8'h40;
      4'd8:    return 8'h80;
      4'd9:    return 8'h1b;
      4'd10:   return 8'h36;
      default: return 8'h00;
    endcase
  endfunction

  // Next round key from the previous one
  always_comb begin
    logic [31:0] w0;
    logic [31:0] w1;
    logic [31:0] w2;
    logic [31:0] w3;
    logic [31:0] rot;
    logic [31:0] temp;
    w0 = prev_key[127:96];
    w1 = prev_key[95:64];
    w2 = prev_key[63:32];
    w3 = prev_key[31:0];
    // RotWord
    rot = {w3[23:0], w3[31:24]};
    // SubWord then round constant on the top byte
    temp = {sbox_fwd(rot[31:24]), sbox_fwd(rot[23:16]),
            sbox_fwd(rot[15:8]), sbox_fwd(rot[7:0])};
    temp[31:24] = temp[31:24] ^ rcon(key_cmd.key_idx);
    // XOR chain across the words
    next_key[127:96] = w0 ^ temp;
    next_key[95:64]  = w1 ^ next_key[127:96];
    next_key[63:32]  = w2 ^ next_key[95:64];
    next_key[31:0]   = w3 ^ next_key[63:32];
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      prev_key <= '0;
    end else if (key_cmd.key_load) begin
      prev_key <= key;
    end else if (key_cmd.key_step) begin
      prev_key <= next_key;
    end
  end

  // Store write
  always_ff @(posedge clk) begin
    if (key_cmd.key_load) begin
      rk_mem[key_cmd.key_idx] <= to_state(key);
    end else if (key_cmd.key_step) begin
      rk_mem[key_cmd.key_idx] <= to_state(next_key);
    end
  end

  // Combinational read
  assign round_key = rk_mem[key_cmd.key_idx];

endmodule

`default_nettype wire

// File: verilog/aes_sbox_tables.svh
// AES forward and inverse S-box tables
// Indexed by the input byte

`ifndef AES_SBOX_TABLES_SVH
`define AES_SBOX_TABLES_SVH

// SubBytes table for key expansion
localparam logic [7:0] sbox_fwd_table [256] = '{
  8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
  8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
  8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
  8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
  8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
  8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
  8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
  8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
  8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
  8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
  8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
  8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
  8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
  8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
  8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
  8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
  8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
  8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
  8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
  8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
  8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
  8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
  8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
  8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
  8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
  8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
  8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
  8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
  8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
  8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
  8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
  8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
};

// InvSubBytes table for the round datapath
localparam logic [7:0] sbox_inv_table [256] = '{
  8'h52, 8'h09, 8'h6a, 8'hd5, 8'h30, 8'h36, 8'ha5, 8'h38,
  8'hbf, 8'h40, 8'ha3, 8'h9e, 8'h81, 8'hf3, 8'hd7, 8'hfb,
  8'h7c, 8'he3, 8'h39, 8'h82, 8'h9b, 8'h2f, 8'hff, 8'h87,
  8'h34, 8'h8e, 8'h43, 8'h44, 8'hc4, 8'hde, 8'he9, 8'hcb,
  8'h54, 8'h7b, 8'h94, 8'h32, 8'ha6, 8'hc2, 8'h23, 8'h3d,
  8'hee, 8'h4c, 8'h95, 8'h0b, 8'h42, 8'hfa, 8'hc3, 8'h4e,
  8'h08, 8'h2e, 8'ha1, 8'h66, 8'h28, 8'hd9, 8'h24, 8'hb2,
  8'h76, 8'h5b, 8'ha2, 8'h49, 8'h6d, 8'h8b, 8'hd1, 8'h25,
  8'h72, 8'hf8, 8'hf6, 8'h64, 8'h86, 8'h68, 8'h98, 8'h16,
  8'hd4, 8'ha4, 8'h5c, 8'hcc, 8'h5d, 8'h65, 8'hb6, 8'h92,
  8'h6c, 8'h70, 8'h48, 8'h50, 8'hfd, 8'hed, 8'hb9, 8'hda,
  8'h5e, 8'h15, 8'h46, 8'h57, 8'ha7, 8'h8d, 8'h9d, 8'h84,
  8'h90, 8'hd8, 8'hab, 8'h00, 8'h8c, 8'hbc, 8'hd3, 8'h0a,
  8'hf7, 8'he4, 8'h58, 8'h05, 8'hb8, 8'hb3, 8'h45, 8'h06,
  8'hd0, 8'h2c, 8'h1e, 8'h8f, 8'hca, 8'h3f, 8'h0f, 8'h02,
  8'hc1, 8'haf, 8'hbd, 8'h03, 8'h01, 8'h13, 8'h8a, 8'h6b,
  8'h3a, 8'h91, 8'h11, 8'h41, 8'h4f, 8'h67, 8'hdc, 8'hea,
  8'h97, 8'hf2, 8'hcf, 8'hce, 8'hf0, 8'hb4, 8'he6, 8'h73,
  8'h96, 8'hac, 8'h74, 8'h22, 8'he7, 8'had, 8'h35, 8'h85,
  8'he2, 8'hf9, 8'h37, 8'he8, 8'h1c, 8'h75, 8'hdf, 8'h6e,
  8'h47, 8'hf1, 8'h1a, 8'h71, 8'h1d, 8'h29, 8'hc5, 8'h89,
  8'h6f, 8'hb7, 8'h62, 8'h0e, 8'haa, 8'h18, 8'hbe, 8'h1b,
  8'hfc, 8'h56, 8'h3e, 8'h4b, 8'hc6, 8'hd2, 8'h79, 8'h20,
  8'h9a, 8'hdb, 8'hc0, 8'hfe, 8'h78, 8'hcd, 8'h5a, 8'hf4,
  8'h1f, 8'hdd, 8'ha8, 8'h33, 8'h88, 8'h07, 8'hc7, 8'h31,
  8'hb1, 8'h12, 8'h10, 8'h59, 8'h27, 8'h80, 8'hec, 8'h5f,
  8'h60, 8'h51, 8'h7f, 8'ha9, 8'h19, 8'hb5, 8'h4a, 8'h0d,
  8'h2d, 8'he5, 8'h7a, 8'h9f, 8'h93, 8'hc9, 8'h9c, 8'hef,
  8'ha0, 8'he0, 8'h3b, 8'h4d, 8'hae, 8'h2a, 8'hf5, 8'hb0,
  8'hc8, 8'heb, 8'hbb, 8'h3c, 8'h83, 8'h53, 8'h99, 8'h61,
  8'h17, 8'h2b, 8'h04, 8'h7e, 8'hba, 8'h77, 8'hd6, 8'h26,
  8'he1, 8'h69, 8'h14, 8'h63, 8'h55, 8'h21, 8'h0c, 8'h7d
};

`endif
